// ==== hw/isaPkg.sv ====
/* Instruction set definitions: instruction classes, ALU opcodes,
   branch conditions, core operations and field widths */
`default_nettype none

package isaPkg;

    // Field widths of the instruction word
    localparam int offsetWidth     = 20;
    localparam int regIdxWidth     = 4;
    localparam int aluImmWidth     = 8;
    localparam int shiftFieldWidth = 4;

    typedef enum logic [2:0] {
        ClassBranch,
        ClassLoadStore,
        ClassDirect,
        ClassAlu,
        ClassCore,
        ClassIllegal
    } instClassT;

    // Codes not listed here give a zero result
    typedef enum logic [4:0] {
        AluAdd        = 5'd0,
        AluSub        = 5'd1,
        AluAnd        = 5'd2,
        AluOr         = 5'd3,
        AluXor        = 5'd4,
        AluNot        = 5'd5,
        AluShl        = 5'd6,
        AluAsr        = 5'd7,
        AluLsr        = 5'd8,
        AluAndNot     = 5'd11,
        AluSubNoCarry = 5'd14,
        AluAndAlt     = 5'd15
    } aluOpT;

    typedef enum logic [3:0] {
        CondAlways, CondZero, CondNotZero, CondCarry,
        CondNotCarry, CondNeg, CondNotNeg, CondOver,
        CondNotOver, CondAbove, CondBelowEq, CondGreaterEq,
        CondLess, CondGreater, CondLessEq, CondNever
    } condT;

    typedef enum logic [5:0] {
        OpNop  = 6'd0,
        OpHalt = 6'd2
    } coreOpT;

endpackage

`default_nettype wire

// ==== hw/corePkg.sv ====
/* Core-wide widths, register count and the phase encoding */
`default_nettype none

package corePkg;

    localparam int dataWidth = 32;
    localparam int regCount  = 16;

    // One instruction walks Fetch through Writeback or WriteSkip
    typedef enum logic [2:0] {
        PhReset,
        PhFetch,
        PhDecode,
        PhExecute,
        PhMemory,
        PhWriteback,
        PhWriteSkip,
        PhHalt
    } phaseT;

endpackage

`default_nettype wire

// ==== hw/fetchDecode.sv ====
/* Phase sequencer, instruction register and instruction field decode */
`timescale 1ns/10ps
`default_nettype none

module fetchDecode
    import corePkg::*;
    import isaPkg::*;
(
    input  logic                       iClk,
    input  logic                       rstN,
    input  logic [dataWidth-1:0]       memRdata,
    input  logic                       exec,
    output phaseT                      phase,
    output instClassT                  instClass,
    output aluOpT                      aluOp,
    output condT                       cond,
    output logic                       isHalt,
    output logic                       isStore,
    output logic                       isDirectOr,
    output logic [regIdxWidth-1:0]     rdIdxA,
    output logic [regIdxWidth-1:0]     rdIdxB,
    output logic [regIdxWidth-1:0]     dstIdx,
    output logic [offsetWidth-1:0]     offset,
    output logic [aluImmWidth-1:0]     aluImm,
    output logic [shiftFieldWidth-1:0] shiftField,
    output logic                       aluImmMode
);
    logic [dataWidth-1:0] instReg;
    phaseT                nextPhase;

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            phase   <= PhReset;
            instReg <= '0;
        end else begin
            phase <= nextPhase;
            if (phase == PhFetch)
                instReg <= memRdata;
        end
    end

    always_comb begin
        case (phase)
            PhReset:     nextPhase = PhFetch;
            PhFetch:     nextPhase = PhDecode;
            PhDecode:    nextPhase = PhExecute;
            PhExecute:   nextPhase = PhMemory;
            PhMemory:    nextPhase = exec ? PhWriteback : PhWriteSkip;
            PhWriteback: nextPhase = isHalt ? PhHalt : PhFetch;
            PhWriteSkip: nextPhase = isHalt ? PhHalt : PhFetch;
            default:     nextPhase = PhHalt;
        endcase
    end

    // Class by leading bits
    always_comb begin
        casez (instReg[31:26])
            6'b1?????: instClass = ClassBranch;
            6'b01????: instClass = ClassLoadStore;
            6'b001???: instClass = ClassDirect;
            6'b0001??: instClass = ClassAlu;
            6'b000001: instClass = ClassCore;
            default:   instClass = ClassIllegal;
        endcase
    end

    assign offset     = instReg[offsetWidth-1:0];
    assign aluImm     = instReg[aluImmWidth-1:0];
    assign isStore    = (instClass == ClassLoadStore) && instReg[29];
    assign isDirectOr = (instClass == ClassDirect) && instReg[28];
    assign aluImmMode = (instClass == ClassAlu) && instReg[27];
    assign isHalt     = (instClass == ClassCore) && (instReg[25:20] == OpHalt);
    assign aluOp      = (instClass == ClassAlu) ? aluOpT'(instReg[24:20]) : AluAdd;
    assign cond       = (instClass == ClassBranch) ? condT'(instReg[27:24]) : CondAlways;

    // Register indices; bits 23..20 hold the branch base and the direct shift
    always_comb begin
        rdIdxA     = '0;
        rdIdxB     = '0;
        dstIdx     = '0;
        shiftField = instReg[23:20];
        case (instClass)
            ClassBranch: rdIdxA = instReg[23:20];
            ClassLoadStore: begin
                rdIdxA = instReg[27:24];
                rdIdxB = instReg[23:20];
                dstIdx = instReg[23:20];
            end
            ClassDirect: begin
                rdIdxA = instReg[27:24];
                dstIdx = instReg[27:24];
            end
            ClassAlu: begin
                rdIdxA     = instReg[15:12];
                rdIdxB     = instReg[11:8];
                dstIdx     = instReg[19:16];
                shiftField = instReg[11:8];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
/* General register file, sixteen entries, two reads and one write */
`timescale 1ns/10ps
`default_nettype none

module regFile
    import corePkg::*;
(
    input  logic                        iClk,
    input  logic                        rstN,
    input  logic [$clog2(regCount)-1:0] rdIdxA,
    input  logic [$clog2(regCount)-1:0] rdIdxB,
    input  logic                        wrEn,
    input  logic [$clog2(regCount)-1:0] wrIdx,
    input  logic [dataWidth-1:0]        wrData,
    output logic [dataWidth-1:0]        rdDataA,
    output logic [dataWidth-1:0]        rdDataB
);
    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Reads are combinational
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

// ==== hw/aluExecute.sv ====
/* Operand registers, ALU, flag register and branch condition check */
`timescale 1ns/10ps
`default_nettype none

module aluExecute
    import corePkg::*;
    import isaPkg::*;
(
    input  logic                       iClk,
    input  logic                       rstN,
    input  phaseT                      phase,
    input  instClassT                  instClass,
    input  aluOpT                      aluOp,
    input  condT                       cond,
    input  logic [offsetWidth-1:0]     offset,
    input  logic [aluImmWidth-1:0]     aluImm,
    input  logic [shiftFieldWidth-1:0] shiftField,
    input  logic                       aluImmMode,
    input  logic                       isDirectOr,
    input  logic [dataWidth-1:0]       rdDataA,
    input  logic [dataWidth-1:0]       rdDataB,
    input  logic [dataWidth-1:0]       ipValue,
    output logic [dataWidth-1:0]       result,
    output logic [dataWidth-1:0]       storeData,
    output logic                       exec
);
    localparam int msb = dataWidth - 1;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth:0]   aluOut;
    logic [dataWidth:0]   resultReg;
    aluOpT                effOp;
    logic                 carryIn;
    logic                 condMet;
    logic                 overflow;
    logic                 flagCarry;
    logic                 flagZero;
    logic                 flagNeg;
    logic                 flagOver;

    always_ff @(posedge iClk) begin
        if (phase == PhDecode) begin
            // Branch base 0 reads the IP
            opA       <= (instClass == ClassBranch && shiftField == '0) ? ipValue : rdDataA;
            storeData <= rdDataB;
            if (instClass == ClassBranch)
                opB <= {{(dataWidth - offsetWidth){offset[offsetWidth-1]}}, offset};
            else if (instClass == ClassLoadStore)
                opB <= {{(dataWidth - offsetWidth){1'b0}}, offset};
            else if (instClass == ClassDirect)
                opB <= {{(dataWidth - offsetWidth){1'b0}}, offset} << shiftField;
            else if (instClass == ClassAlu && aluImmMode)
                opB <= {{(dataWidth - aluImmWidth){1'b0}}, aluImm} << {shiftField, 1'b0};
            else
                opB <= rdDataB;
        end
        if (phase == PhExecute)
            resultReg <= aluOut;
    end

    // Carry only feeds real ALU instructions
    assign effOp   = (instClass == ClassDirect && isDirectOr) ? AluOr : aluOp;
    assign carryIn = (instClass == ClassAlu) && flagCarry;

    always_comb begin
        case (effOp)
            AluAdd:        aluOut = {1'b0, opA} + {1'b0, opB} + carryIn;
            AluSub:        aluOut = {1'b0, opA} - ({1'b0, opB} + carryIn);
            AluAnd:        aluOut = {1'b0, opA & opB};
            AluOr:         aluOut = {1'b0, opA | opB};
            AluXor:        aluOut = {1'b0, opA ^ opB};
            AluNot:        aluOut = {1'b0, ~opA};
            AluShl:        aluOut = {1'b0, opA} << opB;
            AluAsr:        aluOut = {1'b0, $signed(opA) >>> opB};
            AluLsr:        aluOut = {1'b0, opA >> opB};
            AluAndNot:     aluOut = {1'b0, opA & ~opB};
            AluSubNoCarry: aluOut = {1'b0, opA} - {1'b0, opB};
            AluAndAlt:     aluOut = {1'b0, opA & opB};
            default:       aluOut = '0;
        endcase
        // Plain direct write passes the shifted value
        if (instClass == ClassDirect && !isDirectOr)
            aluOut = {1'b0, opB};
    end

    always_comb begin
        case (aluOp)
            AluAdd:  overflow = (opA[msb] == opB[msb]) && (resultReg[msb] != opA[msb]);
            AluSub:  overflow = (opA[msb] != opB[msb]) && (resultReg[msb] != opA[msb]);
            default: overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (cond)
            CondAlways:    condMet = 1'b1;
            CondZero:      condMet = flagZero;
            CondNotZero:   condMet = !flagZero;
            CondCarry:     condMet = flagCarry;
            CondNotCarry:  condMet = !flagCarry;
            CondNeg:       condMet = flagNeg;
            CondNotNeg:    condMet = !flagNeg;
            CondOver:      condMet = flagOver;
            CondNotOver:   condMet = !flagOver;
            CondAbove:     condMet = flagCarry && !flagZero;
            CondBelowEq:   condMet = !flagCarry || flagZero;
            CondGreaterEq: condMet = flagNeg == flagOver;
            CondLess:      condMet = flagNeg != flagOver;
            CondGreater:   condMet = !flagZero && (flagNeg == flagOver);
            CondLessEq:    condMet = flagZero || (flagNeg != flagOver);
            default:       condMet = 1'b0;
        endcase
    end

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            exec      <= 1'b0;
            flagCarry <= 1'b0;
            flagZero  <= 1'b0;
            flagNeg   <= 1'b0;
            flagOver  <= 1'b0;
        end else begin
            if (phase == PhExecute)
                exec <= (instClass != ClassBranch) || condMet;
            if (phase == PhWriteback && instClass == ClassAlu) begin
                flagCarry <= resultReg[dataWidth];
                flagZero  <= (resultReg[msb:0] == '0);
                flagNeg   <= resultReg[msb];
                flagOver  <= overflow;
            end
        end
    end

    assign result = resultReg[msb:0];

endmodule

`default_nettype wire

// ==== hw/memWriteback.sv ====
/* Memory bus drive, load capture, IP update and register write select */
`timescale 1ns/10ps
`default_nettype none

module memWriteback
    import corePkg::*;
    import isaPkg::*;
(
    input  logic                   iClk,
    input  logic                   rstN,
    input  phaseT                  phase,
    input  instClassT              instClass,
    input  logic                   isStore,
    input  logic [regIdxWidth-1:0] dstIdx,
    input  logic [dataWidth-1:0]   result,
    input  logic [dataWidth-1:0]   storeData,
    input  logic                   exec,
    input  logic [dataWidth-1:0]   memRdata,
    output logic [dataWidth-1:0]   memAddr,
    output logic                   memWrite,
    output logic [dataWidth-1:0]   memWdata,
    output logic [dataWidth-1:0]   ipValue,
    output logic                   wrEn,
    output logic [regIdxWidth-1:0] wrIdx,
    output logic [dataWidth-1:0]   wrData
);
    logic                 isLoad;
    logic                 memAccess;
    logic [dataWidth-1:0] loadData;

    assign isLoad    = (instClass == ClassLoadStore) && !isStore;
    assign memAccess = (phase == PhMemory) && (instClass == ClassLoadStore);

    // IP in Fetch, computed address in Memory
    assign memAddr  = (phase == PhFetch) ? ipValue : (memAccess ? result : '0);
    assign memWrite = (phase == PhMemory) && isStore;
    assign memWdata = storeData;

    always_ff @(posedge iClk) begin
        if (memAccess && isLoad)
            loadData <= memRdata;
    end

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            ipValue <= '0;
        end else if (phase == PhWriteback) begin
            if (instClass == ClassBranch && exec)
                ipValue <= result;
            else
                ipValue <= ipValue + 1'b1;
        end else if (phase == PhWriteSkip) begin
            ipValue <= ipValue + 1'b1;
        end
    end

    assign wrEn   = (phase == PhWriteback) &&
                    (instClass == ClassAlu || instClass == ClassDirect || isLoad);
    assign wrIdx  = dstIdx;
    assign wrData = isLoad ? loadData : result;

endmodule

`default_nettype wire

// ==== hw/cpuCore.sv ====
/* CPU top level joining fetch/decode, registers, execute and writeback */
`timescale 1ns/10ps
`default_nettype none

module cpuCore
    import corePkg::*;
    import isaPkg::*;
(
    input  logic                 iClk,
    input  logic                 rstN,
    output logic [dataWidth-1:0] memAddr,
    output logic                 memWrite,
    output logic [dataWidth-1:0] memWdata,
    input  logic [dataWidth-1:0] memRdata,
    output logic                 halt
);
    phaseT                      phase;
    instClassT                  instClass;
    aluOpT                      aluOp;
    condT                       cond;
    logic                       isHalt;
    logic                       isStore;
    logic                       isDirectOr;
    logic                       aluImmMode;
    logic                       exec;
    logic                       wrEn;
    logic [regIdxWidth-1:0]     rdIdxA;
    logic [regIdxWidth-1:0]     rdIdxB;
    logic [regIdxWidth-1:0]     dstIdx;
    logic [regIdxWidth-1:0]     wrIdx;
    logic [offsetWidth-1:0]     offset;
    logic [aluImmWidth-1:0]     aluImm;
    logic [shiftFieldWidth-1:0] shiftField;
    logic [dataWidth-1:0]       rdDataA;
    logic [dataWidth-1:0]       rdDataB;
    logic [dataWidth-1:0]       wrData;
    logic [dataWidth-1:0]       result;
    logic [dataWidth-1:0]       storeData;
    logic [dataWidth-1:0]       ipValue;

    fetchDecode u_fetchDecode (
        .iClk(iClk), .rstN(rstN), .memRdata(memRdata), .exec(exec),
        .phase(phase), .instClass(instClass), .aluOp(aluOp), .cond(cond),
        .isHalt(isHalt), .isStore(isStore), .isDirectOr(isDirectOr),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .dstIdx(dstIdx), .offset(offset),
        .aluImm(aluImm), .shiftField(shiftField), .aluImmMode(aluImmMode)
    );

    regFile u_regFile (
        .iClk(iClk), .rstN(rstN), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    aluExecute u_aluExecute (
        .iClk(iClk), .rstN(rstN), .phase(phase), .instClass(instClass),
        .aluOp(aluOp), .cond(cond), .offset(offset), .aluImm(aluImm),
        .shiftField(shiftField), .aluImmMode(aluImmMode), .isDirectOr(isDirectOr),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .ipValue(ipValue),
        .result(result), .storeData(storeData), .exec(exec)
    );

    memWriteback u_memWriteback (
        .iClk(iClk), .rstN(rstN), .phase(phase), .instClass(instClass),
        .isStore(isStore), .dstIdx(dstIdx), .result(result), .storeData(storeData),
        .exec(exec), .memRdata(memRdata), .memAddr(memAddr), .memWrite(memWrite),
        .memWdata(memWdata), .ipValue(ipValue), .wrEn(wrEn), .wrIdx(wrIdx),
        .wrData(wrData)
    );

    assign halt = (phase == PhHalt);

endmodule

`default_nettype wire

// ==== tb/refModel.svh ====
/* LFSR stimulus source and instruction-set reference model */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [15:0] lfsrState;
logic [31:0] refMem [256];
logic [31:0] expAddr [$];
logic [31:0] expData [$];

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], lfsrStep()};
    return v;
endfunction

// Bit 32 is the carry out
function automatic logic [32:0] aluRef(input logic [4:0] op, input logic [31:0] a,
                                       input logic [31:0] b, input logic cin);
    logic [31:0] sra;
    sra = $signed(a) >>> b;
    case (op)
        5'd0:        return {1'b0, a} + {1'b0, b} + cin;
        5'd1:        return {1'b0, a} - {1'b0, b} - cin;
        5'd2, 5'd15: return {1'b0, a & b};
        5'd3:        return {1'b0, a | b};
        5'd4:        return {1'b0, a ^ b};
        5'd5:        return {1'b0, ~a};
        5'd6:        return {1'b0, a} << b;
        5'd7:        return {1'b0, sra};
        5'd8:        return {1'b0, a >> b};
        5'd11:       return {1'b0, a & ~b};
        5'd14:       return {1'b0, a} - {1'b0, b};
        default:     return '0;
    endcase
endfunction

function automatic logic condHolds(input logic [3:0] c, input logic cF, input logic zF,
                                   input logic nF, input logic vF);
    case (c)
        4'd0:    return 1'b1;
        4'd1:    return zF;
        4'd2:    return !zF;
        4'd3:    return cF;
        4'd4:    return !cF;
        4'd5:    return nF;
        4'd6:    return !nF;
        4'd7:    return vF;
        4'd8:    return !vF;
        4'd9:    return cF && !zF;
        4'd10:   return !cF || zF;
        4'd11:   return nF == vF;
        4'd12:   return nF != vF;
        4'd13:   return !zF && (nF == vF);
        4'd14:   return zF || (nF != vF);
        default: return 1'b0;
    endcase
endfunction

// Runs refMem from address 0 to the halt, returns the instruction count
function automatic int runReference();
    logic [31:0] regs [16];
    logic [31:0] ip;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [32:0] wide;
    logic        cF;
    logic        zF;
    logic        nF;
    logic        vF;
    int          count;
    for (int i = 0; i < 16; i++)
        regs[i] = '0;
    ip = '0;
    {cF, zF, nF, vF} = 4'b0;
    count = 0;
    expAddr.delete();
    expData.delete();
    while (count < 2000) begin
        inst = refMem[ip[7:0]];
        count++;
        if (inst[31]) begin
            a = (inst[23:20] == 4'd0) ? ip : regs[inst[23:20]];
            b = {{12{inst[19]}}, inst[19:0]};
            ip = condHolds(inst[27:24], cF, zF, nF, vF) ? a + b : ip + 1;
        end else if (inst[31:30] == 2'b01) begin
            ea = regs[inst[27:24]] + {12'b0, inst[19:0]};
            if (inst[29]) begin
                expAddr.push_back(ea);
                expData.push_back(regs[inst[23:20]]);
                refMem[ea[7:0]] = regs[inst[23:20]];
            end else begin
                regs[inst[23:20]] = refMem[ea[7:0]];
            end
            ip = ip + 1;
        end else if (inst[31:29] == 3'b001) begin
            b = {12'b0, inst[19:0]} << inst[23:20];
            regs[inst[27:24]] = inst[28] ? (regs[inst[27:24]] | b) : b;
            ip = ip + 1;
        end else if (inst[31:28] == 4'b0001) begin
            a = regs[inst[15:12]];
            b = inst[27] ? ({24'b0, inst[7:0]} << {inst[11:8], 1'b0}) : regs[inst[11:8]];
            wide = aluRef(inst[24:20], a, b, cF);
            // Signed overflow of add and subtract
            if (inst[24:20] == 5'd0)
                vF = (a[31] == b[31]) && (wide[31] != a[31]);
            else if (inst[24:20] == 5'd1)
                vF = (a[31] != b[31]) && (wide[31] != a[31]);
            else
                vF = 1'b0;
            cF = wide[32];
            zF = (wide[31:0] == '0);
            nF = wide[31];
            regs[inst[19:16]] = wide[31:0];
            ip = ip + 1;
        end else if (inst[31:26] == 6'b000001 && inst[25:20] == 6'd2) begin
            return count;
        end else begin
            ip = ip + 1;
        end
    end
    return count;
endfunction

`endif

// ==== tb/tbCore.sv ====
/* Testbench for cpuCore: memory model, program builder, store checker */
`timescale 1ns/10ps
`default_nettype none

module tbCore
    import isaPkg::*;
();
    localparam int numTests = 5;

    logic        iClk;
    logic        rstN;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic        memWrite;
    logic        halt;
    logic [31:0] mem [256];

    int pc;
    int errorCount;
    int testErrors;
    int testsFailed;
    int storeIdx;
    int storesSeen;
    int relCycles;
    int cycleCount;
    int cycleLimit;
    bit running;

    `include "refModel.svh"

    cpuCore u_dut (
        .iClk(iClk), .rstN(rstN), .memAddr(memAddr), .memWrite(memWrite),
        .memWdata(memWdata), .memRdata(memRdata), .halt(halt)
    );

    assign memRdata = mem[memAddr[7:0]];

    initial begin
        iClk = 1'b0;
        forever #50 iClk = ~iClk;
    end

    always @(posedge iClk) begin
        if (memWrite)
            mem[memAddr[7:0]] <= memWdata;
    end

    always @(posedge iClk) begin
        cycleCount++;
        if (!rstN)
            relCycles = 0;
        else
            relCycles++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: run passed %0d cycles without finishing", cycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic noteError();
        errorCount++;
        testErrors++;
    endtask

    // Store log against the reference
    always @(posedge iClk) begin
        if (running && rstN && memWrite) begin
            storesSeen++;
            if (halt) begin
                $display("Store seen after the core halted");
                noteError();
            end else if (storeIdx >= expAddr.size()) begin
                $display("Store at %h that the reference does not make", memAddr);
                noteError();
            end else begin
                if (memAddr != expAddr[storeIdx]) begin
                    $display("Fail memAddr got %h expected %h", memAddr, expAddr[storeIdx]);
                    noteError();
                end
                if (memWdata != expData[storeIdx]) begin
                    $display("Fail memWdata got %h expected %h", memWdata, expData[storeIdx]);
                    noteError();
                end
                storeIdx++;
            end
        end
    end

    always @(negedge iClk) begin
        if (running && memWrite && (!rstN || relCycles <= 1)) begin
            $display("memWrite went high during reset or the first fetch");
            noteError();
        end
    end

    function automatic logic [31:0] encDirect(input logic [3:0] dst, input logic orFlag,
                                              input logic [3:0] shift, input logic [19:0] val);
        return {3'b001, orFlag, dst, shift, val};
    endfunction

    function automatic logic [31:0] encAlu(input logic [4:0] op, input logic [3:0] dst,
                                           input logic [3:0] srcA, input logic immMode,
                                           input logic [3:0] fieldB, input logic [7:0] imm);
        return {4'b0001, immMode, 2'b00, op, dst, srcA, fieldB, imm};
    endfunction

    function automatic logic [31:0] encMem(input logic store, input logic [3:0] base,
                                           input logic [3:0] data, input logic [19:0] off);
        return {2'b01, store, 1'b0, base, data, off};
    endfunction

    function automatic logic [31:0] encBranch(input logic [3:0] c, input logic [3:0] base,
                                              input logic [19:0] off);
        return {1'b1, 3'b000, c, base, off};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[pc] = w;
        pc++;
    endtask

    task automatic loadConst(input logic [3:0] r, input logic [31:0] c);
        emit(encDirect(r, 1'b0, 4'd12, c[31:12]));
        emit(encDirect(r, 1'b1, 4'd0, {8'h0, c[11:0]}));
    endtask

    // r15 stays zero and serves as the absolute base
    task automatic buildProgram(input int t);
        logic [31:0] c;
        logic [19:0] v;
        logic [3:0]  s;
        logic [4:0]  op;
        for (int a = 0; a < 256; a++)
            mem[a] = {a[7:0], ~a[7:0], a[7:0] ^ 8'ha5, 8'h3c};
        pc = 0;
        case (t)
            1: begin
                for (int k = 0; k < 6; k++) begin
                    c = randBits(32);
                    loadConst(4'(k + 1), c);
                    emit(encMem(1'b1, 4'd15, 4'(k + 1), 20'(128 + k)));
                end
                s = randBits(4);
                v = randBits(20);
                emit(encDirect(4'd7, 1'b0, s, v));
                emit(encMem(1'b1, 4'd15, 4'd7, 20'd134));
                s = randBits(4);
                v = randBits(20);
                emit(encDirect(4'd7, 1'b1, s, v));
                emit(encMem(1'b1, 4'd15, 4'd7, 20'd135));
            end
            2: begin
                for (int k = 0; k < 12; k++) begin
                    c = randBits(32);
                    loadConst(4'd1, c);
                    s = randBits(4);
                    v = randBits(20);
                    emit(encDirect(4'd2, 1'b0, s, v));
                    op = 5'(randBits(4));
                    if (op inside {AluShl, AluAsr, AluLsr}) begin
                        c = randBits(5);
                        emit(encAlu(op, 4'd3, 4'd1, 1'b1, 4'd0, c[7:0]));
                    end else if (randBits(2) == 0) begin
                        s = randBits(4);
                        c = randBits(8);
                        emit(encAlu(op, 4'd3, 4'd1, 1'b1, s, c[7:0]));
                    end else begin
                        emit(encAlu(op, 4'd3, 4'd1, 1'b0, 4'd2, 8'h0));
                    end
                    emit(encMem(1'b1, 4'd15, 4'd3, 20'(144 + k)));
                end
            end
            3: begin
                for (int k = 0; k < 8; k++) begin
                    mem[200 + k] = randBits(32);
                    emit(encMem(1'b0, 4'd15, 4'd4, 20'(200 + k)));
                    emit(encMem(1'b1, 4'd15, 4'd4, 20'(160 + k)));
                end
            end
            4: begin
                for (int k = 0; k < 16; k++) begin
                    s = randBits(4);
                    v = randBits(20);
                    emit(encDirect(4'd1, 1'b0, s, v));
                    // Equal operands now and then to reach the zero flag
                    if (randBits(1) == 1'b1) begin
                        emit(encDirect(4'd2, 1'b0, s, v));
                    end else begin
                        s = randBits(4);
                        v = randBits(20);
                        emit(encDirect(4'd2, 1'b0, s, v));
                    end
                    c = randBits(2);
                    case (c[1:0])
                        2'd0:    op = AluAdd;
                        2'd1:    op = AluSub;
                        2'd2:    op = AluSubNoCarry;
                        default: op = AluXor;
                    endcase
                    emit(encAlu(op, 4'd3, 4'd1, 1'b0, 4'd2, 8'h0));
                    emit(encDirect(4'd5, 1'b0, 4'd0, 20'(20'h500 + k)));
                    emit(encBranch(4'(k), 4'd0, 20'd2));
                    emit(encMem(1'b1, 4'd15, 4'd5, 20'(176 + k)));
                end
            end
            default: begin
                emit(encDirect(4'd1, 1'b0, 4'd0, 20'h12345));
                emit(encMem(1'b1, 4'd15, 4'd1, 20'd220));
                emit({6'b000001, 6'd2, 20'd0});
                emit(encMem(1'b1, 4'd15, 4'd1, 20'd221));
                emit(encMem(1'b1, 4'd15, 4'd1, 20'd222));
            end
        endcase
        emit({6'b000001, 6'd2, 20'd0});
        for (int a = 0; a < 256; a++)
            refMem[a] = mem[a];
    endtask

    task automatic runTest(input int t);
        int n;
        rstN = 1'b0;
        buildProgram(t);
        n = runReference();
        storeIdx = 0;
        storesSeen = 0;
        testErrors = 0;
        running = 1'b1;
        repeat (5) @(negedge iClk);
        rstN = 1'b1;
        while (!halt)
            @(negedge iClk);
        if (relCycles != 1 + 5 * n) begin
            $display("Fail halt cycle got %h expected %h", relCycles, 1 + 5 * n);
            noteError();
        end
        repeat (3) @(negedge iClk);
        if (storesSeen != expAddr.size()) begin
            $display("Fail storeCount got %h expected %h", storesSeen, expAddr.size());
            noteError();
        end
        for (int a = 0; a < 256; a++) begin
            if (mem[a] != refMem[a]) begin
                $display("Fail mem[%h] got %h expected %h", a[7:0], mem[a], refMem[a]);
                noteError();
            end
        end
        running = 1'b0;
        if (testErrors != 0)
            testsFailed++;
        $display("Test %0d: %0d instructions, %0d stores, %0d errors", t, n, storesSeen,
                 testErrors);
    endtask

    initial begin
        int total;
        rstN = 1'b0;
        running = 1'b0;
        errorCount = 0;
        testsFailed = 0;
        cycleCount = 0;
        cycleLimit = 0;
        relCycles = 0;
        pc = 0;
        lfsrState = 16'd60652;
        total = 0;
        // Dry pass sizes the run limit
        for (int t = 1; t <= numTests; t++) begin
            buildProgram(t);
            total += runReference();
        end
        lfsrState = 16'd60652;
        @(negedge iClk);
        cycleCount = 0;
        cycleLimit = 5 * total + numTests * 10 + 50;
        for (int t = 1; t <= numTests; t++)
            runTest(t);
        $display("Tests %0d, passed %0d, failed %0d, errors %0d", numTests,
                 numTests - testsFailed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
hw/isaPkg.sv
hw/corePkg.sv
hw/fetchDecode.sv
hw/regFile.sv
hw/aluExecute.sv
hw/memWriteback.sv
hw/cpuCore.sv
tb/tbCore.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - hw/isaPkg.sv
  - hw/corePkg.sv
  - hw/fetchDecode.sv
  - hw/regFile.sv
  - hw/aluExecute.sv
  - hw/memWriteback.sv
  - hw/cpuCore.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbCore.sv
